// File: common/mul_cfg.svh
// Configuration macros for the multiply unit: operand width, core stage count, tag width
`ifndef MUL_CFG_SVH
`define MUL_CFG_SVH

// --------------------
// Datapath
// --------------------

// Operand and result width of the RV32 datapath
`define MUL_XLEN 32

// Register stages inside the array multiplier core
// The core needs at least two stages to build its valid pipe
`define MUL_CORE_STAGES 4

// --------------------
// Writeback
// --------------------

// Width of the destination register index carried with each operation
`define MUL_TAG_W 5

`endif

// File: common/mul_pkg.sv
// Multiply unit package with the operation enum, data word, tag and product union types
`include "mul_cfg.svh"

package mul_pkg;

    // --------------------
    // Operations
    // --------------------

    // Encoding follows funct3 of the M-extension multiply group
    typedef enum logic [1:0] {
        MUL    = 2'b00,
        MULH   = 2'b01,
        MULHSU = 2'b10,
        MULHU  = 2'b11
    } mul_uop_t;

    // --------------------
    // Data and tags
    // --------------------

    // One register-file word
    typedef logic [`MUL_XLEN - 1:0] data_word_t;

    // Index of the destination register where zero means x0
    typedef logic [`MUL_TAG_W - 1:0] mul_tag_t;

    // Upper and lower words of the double-width product
    typedef struct packed {
        data_word_t hi;
        data_word_t lo;
    } mul_halves_t;

    // The final stage writes the whole product and reads back one half
    typedef union packed {
        logic [2 * `MUL_XLEN - 1:0] full;
        mul_halves_t                halves;
    } mul_product_t;

endpackage : mul_pkg

// File: compile.f
+incdir+common
common/mul_pkg.sv
mul_unit/pipelined_array_multiplier.sv
mul_unit/mul_unit.sv
rtl/mul_tag_pipe.sv
rtl/mul_top.sv
testbench/mul_tb.sv

// File: mul_unit/mul_unit.sv
// RV32 multiply unit with sign conversion, control pipe, array core and half selection
`timescale 1ns/1ps
`include "mul_cfg.svh"

module mul_unit import mul_pkg::*; #(
    parameter int CORE_STAGES = `MUL_CORE_STAGES
) (
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       clk_en_i,
    input  logic       valid_i,
    input  mul_uop_t   op_i,
    input  data_word_t multiplicand_i,
    input  data_word_t multiplier_i,
    output data_word_t product_o,
    output logic       valid_o
);

    localparam int XLEN = $bits(data_word_t);

    // --------------------
    // Sign conversion
    // --------------------

    // rs1 is the multiplicand and rs2 the multiplier
    logic       rs1_signed;
    logic       rs2_signed;
    logic       rs1_neg;
    logic       rs2_neg;
    logic       negate;
    data_word_t rs1_mag;
    data_word_t rs2_mag;

    // Only MULHU treats rs1 as unsigned, and only MUL and MULH treat rs2 as signed
    assign rs1_signed = (op_i != MULHU);
    assign rs2_signed = (op_i == MUL) || (op_i == MULH);

    // An operand counts as negative only when it sits in a signed position
    assign rs1_neg = rs1_signed & multiplicand_i[XLEN - 1];
    assign rs2_neg = rs2_signed & multiplier_i[XLEN - 1];

    // The core is unsigned, so negative operands enter as two's-complement magnitudes
    // The most negative value maps onto itself, which is its correct unsigned magnitude
    assign rs1_mag = rs1_neg ? (~multiplicand_i + 1'b1) : multiplicand_i;
    assign rs2_mag = rs2_neg ? (~multiplier_i + 1'b1) : multiplier_i;

    // The product is negative exactly when one effective sign is set
    assign negate = rs1_neg ^ rs2_neg;

    // --------------------
    // Operand register
    // --------------------

    data_word_t rs1_mag_stg0;
    data_word_t rs2_mag_stg0;
    logic       negate_stg0;
    mul_uop_t   op_stg0;
    logic       valid_stg0;

    always_ff @(posedge clk_i) begin
        if (clk_en_i) begin
            rs1_mag_stg0 <= rs1_mag;
            rs2_mag_stg0 <= rs2_mag;
            negate_stg0  <= negate;
            op_stg0      <= op_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_stg0 <= 1'b0;
        end else if (clk_en_i) begin
            valid_stg0 <= valid_i;
        end
    end

    // --------------------
    // Control pipe
    // --------------------

    // Both pipes are one entry deeper than the core to cover the last-stage register
    logic [CORE_STAGES:0] negate_pipe;
    mul_uop_t             op_pipe [CORE_STAGES + 1];

    always_ff @(posedge clk_i) begin
        if (clk_en_i) begin
            negate_pipe <= {negate_pipe[CORE_STAGES - 1:0], negate_stg0};
            op_pipe[0]  <= op_stg0;
            for (int i = 1; i <= CORE_STAGES; i++) begin
                op_pipe[i] <= op_pipe[i - 1];
            end
        end
    end

    // --------------------
    // Core multiplier
    // --------------------

    logic [2 * XLEN - 1:0] core_product;
    logic                  core_valid;

    pipelined_array_multiplier #(
        .DATA_WIDTH (XLEN),
        .STAGES     (CORE_STAGES)
    ) u_core (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .clk_en_i       (clk_en_i),
        .multiplicand_i (rs1_mag_stg0),
        .multiplier_i   (rs2_mag_stg0),
        .valid_i        (valid_stg0),
        .product_o      (core_product),
        .valid_o        (core_valid)
    );

    // --------------------
    // Last stage
    // --------------------

    logic [2 * XLEN - 1:0] last_product_q;
    logic                  last_valid_q;
    mul_product_t          result;

    always_ff @(posedge clk_i) begin
        if (clk_en_i) begin
            last_product_q <= core_product;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            last_valid_q <= 1'b0;
        end else if (clk_en_i) begin
            last_valid_q <= core_valid;
        end
    end

    // Restore the sign over the full double-width product before picking a half
    always_comb begin
        if (negate_pipe[CORE_STAGES]) begin
            result.full = ~last_product_q + 1'b1;
        end else begin
            result.full = last_product_q;
        end

        // MUL keeps the low word, the three high variants keep the upper word
        if (op_pipe[CORE_STAGES] == MUL) begin
            product_o = result.halves.lo;
        end else begin
            product_o = result.halves.hi;
        end
    end

    assign valid_o = last_valid_q;

endmodule : mul_unit

// File: mul_unit/pipelined_array_multiplier.sv
// Unsigned array multiplier split into register stages, with a valid pipe beside the data
`timescale 1ns/1ps

module pipelined_array_multiplier #(
    parameter int DATA_WIDTH = 32,
    parameter int STAGES     = 4
) (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        clk_en_i,
    input  logic [DATA_WIDTH - 1:0]     multiplicand_i,
    input  logic [DATA_WIDTH - 1:0]     multiplier_i,
    input  logic                        valid_i,
    output logic [2 * DATA_WIDTH - 1:0] product_o,
    output logic                        valid_o
);

    localparam int PROD_WIDTH = 2 * DATA_WIDTH;

    // Each stage sums this many partial-product rows and the division rounds up to cover all rows
    localparam int ROWS_PER_STAGE = (DATA_WIDTH + STAGES - 1) / STAGES;

    // Registered partial sum of each stage
    // The sum of the last stage is the finished product
    logic [PROD_WIDTH - 1:0] sum_q [STAGES];

    // Operands travel with the sum because later stages still need their rows
    logic [DATA_WIDTH - 1:0] mcand_q [STAGES - 1];
    logic [DATA_WIDTH - 1:0] mplier_q [STAGES - 1];

    // One valid bit per stage
    logic [STAGES - 1:0] valid_q;

    // --------------------
    // Stage array
    // --------------------

    genvar s;
    generate
        for (s = 0; s < STAGES; s++) begin : g_stage
            // Rows handled here are FIRST_ROW up to but not including LAST_ROW
            localparam int FIRST_ROW = s * ROWS_PER_STAGE;
            localparam int LAST_ROW  = ((s + 1) * ROWS_PER_STAGE > DATA_WIDTH) ?
                                       DATA_WIDTH : (s + 1) * ROWS_PER_STAGE;

            logic [DATA_WIDTH - 1:0] mcand;
            logic [DATA_WIDTH - 1:0] mplier;
            logic [PROD_WIDTH - 1:0] sum_in;
            logic [PROD_WIDTH - 1:0] sum_out;

            // The first stage starts from zero and takes the operands straight from the ports
            if (s == 0) begin : g_first
                assign mcand  = multiplicand_i;
                assign mplier = multiplier_i;
                assign sum_in = '0;
            end else begin : g_next
                assign mcand  = mcand_q[s - 1];
                assign mplier = mplier_q[s - 1];
                assign sum_in = sum_q[s - 1];
            end

            // Each set multiplier bit adds the shifted multiplicand as one row
            always_comb begin
                sum_out = sum_in;
                for (int r = FIRST_ROW; r < LAST_ROW; r++) begin
                    if (mplier[r]) begin
                        sum_out = sum_out + (PROD_WIDTH'(mcand) << r);
                    end
                end
            end

            always_ff @(posedge clk_i) begin
                if (clk_en_i) begin
                    sum_q[s] <= sum_out;
                end
            end

            // The last stage has no successor, so its operands are not kept
            if (s < STAGES - 1) begin : g_fwd
                always_ff @(posedge clk_i) begin
                    if (clk_en_i) begin
                        mcand_q[s]  <= mcand;
                        mplier_q[s] <= mplier;
                    end
                end
            end
        end
    endgenerate

    // --------------------
    // Valid pipe
    // --------------------

    // The valid bits advance one stage on every enabled edge
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (clk_en_i) begin
            valid_q <= {valid_q[STAGES - 2:0], valid_i};
        end
    end

    assign product_o = sum_q[STAGES - 1];
    assign valid_o   = valid_q[STAGES - 1];

endmodule : pipelined_array_multiplier

// File: rtl/mul_tag_pipe.sv
// Destination tag delay line matched to the multiply unit latency
`timescale 1ns/1ps
`include "mul_cfg.svh"

module mul_tag_pipe import mul_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  logic     clk_en_i,
    input  logic     valid_i,
    input  mul_tag_t rd_tag_i,
    output mul_tag_t rd_tag_o
);

    // Operand register, core stages and last-stage register
    localparam int DEPTH = `MUL_CORE_STAGES + 2;

    // --------------------
    // Tag shift register
    // --------------------

    mul_tag_t tag_q [DEPTH];

    // An idle slot carries tag zero, which points at x0 and so writes nothing
    // Slots only move on enabled edges so the tags stay aligned with the product
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < DEPTH; i++) begin
                tag_q[i] <= '0;
            end
        end else if (clk_en_i) begin
            tag_q[0] <= valid_i ? rd_tag_i : '0;
            for (int i = 1; i < DEPTH; i++) begin
                tag_q[i] <= tag_q[i - 1];
            end
        end
    end

    // The oldest slot leaves together with the matching result
    assign rd_tag_o = tag_q[DEPTH - 1];

endmodule : mul_tag_pipe

// File: rtl/mul_top.sv
// Multiply unit top level joining the datapath and the destination tag pipe
`timescale 1ns/1ps
`include "mul_cfg.svh"

module mul_top import mul_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       clk_en_i,
    input  logic       valid_i,
    input  mul_uop_t   op_i,
    input  data_word_t multiplicand_i,
    input  data_word_t multiplier_i,
    input  mul_tag_t   rd_tag_i,
    output data_word_t product_o,
    output mul_tag_t   rd_tag_o,
    output logic       valid_o
);

    // --------------------
    // Datapath
    // --------------------

    // Core depth must match the depth that the tag pipe is built for
    mul_unit #(
        .CORE_STAGES (`MUL_CORE_STAGES)
    ) u_mul_unit (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .clk_en_i       (clk_en_i),
        .valid_i        (valid_i),
        .op_i           (op_i),
        .multiplicand_i (multiplicand_i),
        .multiplier_i   (multiplier_i),
        .product_o      (product_o),
        .valid_o        (valid_o)
    );

    // --------------------
    // Tag pipe
    // --------------------

    mul_tag_pipe u_mul_tag_pipe (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .clk_en_i (clk_en_i),
        .valid_i  (valid_i),
        .rd_tag_i (rd_tag_i),
        .rd_tag_o (rd_tag_o)
    );

endmodule : mul_top

// File: run.sh
#!/bin/sh
# Build the multiply unit simulation with Verilator, run it and look for the pass message
cd "$(dirname "$0")" \
    && verilator --binary -Wno-fatal -f compile.f --top-module mul_tb -o mul_sim \
    && ./obj_dir/mul_sim | tee /dev/stderr | grep -qF '** PASS **' \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: testbench/mul_tb.sv
// Testbench for the multiply top level with reference model, result monitor and directed tests
`timescale 1ns/1ps
`include "mul_cfg.svh"

module mul_tb import mul_pkg::*; ();

    // Operand register, core stages and last-stage register
    localparam int LATENCY     = `MUL_CORE_STAGES + 2;
    localparam int XLEN        = `MUL_XLEN;
    localparam int DRAIN_LIMIT = 200;

    logic       clk_i;
    logic       rst_n_i;
    logic       clk_en_i;
    logic       valid_i;
    mul_uop_t   op_i;
    data_word_t multiplicand_i;
    data_word_t multiplier_i;
    mul_tag_t   rd_tag_i;
    data_word_t product_o;
    mul_tag_t   rd_tag_o;
    logic       valid_o;

    // Expected results in order of acceptance
    data_word_t exp_product_q [$];
    mul_tag_t   exp_tag_q [$];
    integer     seed = 32'hd944;

    // Output values seen at the previous edge let the monitor check that stalls freeze them
    logic       stalled_q;
    logic       held_valid;
    data_word_t held_product;
    mul_tag_t   held_tag;
    data_word_t exp_product;
    mul_tag_t   exp_tag;

    mul_top u_mul_top (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .clk_en_i       (clk_en_i),
        .valid_i        (valid_i),
        .op_i           (op_i),
        .multiplicand_i (multiplicand_i),
        .multiplier_i   (multiplier_i),
        .rd_tag_i       (rd_tag_i),
        .product_o      (product_o),
        .rd_tag_o       (rd_tag_o),
        .valid_o        (valid_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // --------------------
    // Reference model
    // --------------------

    // Extend both operands to double width as RISC-V does, multiply and keep one half
    function automatic data_word_t expected_result(input mul_uop_t op, input data_word_t a,
                                                   input data_word_t b);
        logic [2 * XLEN - 1:0] ext_a;
        logic [2 * XLEN - 1:0] ext_b;
        logic [2 * XLEN - 1:0] full;
        ext_a = (op == MULHU) ? {{XLEN{1'b0}}, a} : {{XLEN{a[XLEN - 1]}}, a};
        ext_b = (op == MUL || op == MULH) ? {{XLEN{b[XLEN - 1]}}, b} : {{XLEN{1'b0}}, b};
        full  = ext_a * ext_b;
        return (op == MUL) ? full[XLEN - 1:0] : full[2 * XLEN - 1:XLEN];
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] expected);
        $display("** Error %s: got 0x%0h, expected 0x%0h", name, got, expected);
        $display("** FAIL **");
        $fatal(1, "value mismatch");
    endtask

    task automatic report_failure(input string what);
        $display("Error: %s", what);
        $display("** FAIL **");
        $fatal(1, "run aborted");
    endtask

    // --------------------
    // Monitor
    // --------------------

    // Pre-edge values are read here, so a result is counted once on the edge that retires it
    always @(posedge clk_i) begin
        if (rst_n_i) begin
            assert (!$isunknown(valid_o)) else report_failure("valid_o is unknown after reset");
            if (stalled_q) begin
                assert (valid_o === held_valid)
                    else report_mismatch("valid_o", valid_o, held_valid);
                assert (product_o === held_product)
                    else report_mismatch("product_o", product_o, held_product);
                assert (rd_tag_o === held_tag)
                    else report_mismatch("rd_tag_o", rd_tag_o, held_tag);
            end
            if (clk_en_i && valid_o) begin
                if (exp_product_q.size() == 0) begin
                    report_failure("a result came out with no operation waiting for it");
                end else begin
                    exp_product = exp_product_q.pop_front();
                    exp_tag     = exp_tag_q.pop_front();
                    assert (product_o === exp_product)
                        else report_mismatch("product_o", product_o, exp_product);
                    assert (rd_tag_o === exp_tag)
                        else report_mismatch("rd_tag_o", rd_tag_o, exp_tag);
                end
            end
            stalled_q    = !clk_en_i;
            held_valid   = valid_o;
            held_product = product_o;
            held_tag     = rd_tag_o;
        end
    end

    // --------------------
    // Drivers
    // --------------------

    task automatic drive_idle(input logic en);
        @(negedge clk_i);
        valid_i  = 1'b0;
        clk_en_i = en;
    endtask

    // Holds the operation on the inputs until an enabled edge takes it
    task automatic issue_op(input mul_uop_t op, input data_word_t a, input data_word_t b,
                            input mul_tag_t tag, input bit stall);
        logic en;
        int   tries;
        en    = 1'b0;
        tries = 0;
        while (!en) begin
            @(negedge clk_i);
            valid_i        = 1'b1;
            op_i           = op;
            multiplicand_i = a;
            multiplier_i   = b;
            rd_tag_i       = tag;
            en             = 1'b1;
            if (stall && tries < 3 && ($random(seed) % 4 == 0)) begin
                en = 1'b0;
            end
            clk_en_i = en;
            tries++;
        end
        exp_product_q.push_back(expected_result(op, a, b));
        exp_tag_q.push_back(tag);
    endtask

    task automatic wait_drain();
        int cycles;
        drive_idle(1'b1);
        cycles = 0;
        while (exp_product_q.size() != 0 && cycles < DRAIN_LIMIT) begin
            @(negedge clk_i);
            cycles++;
        end
        if (exp_product_q.size() != 0) begin
            report_failure("timed out while waiting for outstanding results");
        end
    endtask

    // --------------------
    // Directed tests
    // --------------------

    task automatic check_reset();
        repeat (8) begin
            @(negedge clk_i);
            assert (valid_o === 1'b0) else report_mismatch("valid_o", valid_o, 0);
            assert (rd_tag_o === '0) else report_mismatch("rd_tag_o", rd_tag_o, 0);
        end
    endtask

    // Every operation over every pair of edge values issued back to back
    task automatic test_corners();
        data_word_t corners [5];
        int         n;
        corners = '{32'h0000_0000, 32'h0000_0001, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};
        n = 0;
        for (int op = 0; op < 4; op++) begin
            for (int i = 0; i < 5; i++) begin
                for (int j = 0; j < 5; j++) begin
                    issue_op(mul_uop_t'(op), corners[i], corners[j], mul_tag_t'(n), 1'b0);
                    n++;
                end
            end
        end
        wait_drain();
    endtask

    // valid_o must rise exactly LATENCY enabled edges after the accepting one
    task automatic test_latency();
        issue_op(MULH, 32'h8765_4321, 32'hfedc_ba98, 5'd17, 1'b0);
        for (int k = 1; k <= LATENCY; k++) begin
            @(negedge clk_i);
            valid_i = 1'b0;
            if (k < LATENCY) begin
                assert (valid_o === 1'b0) else report_mismatch("valid_o", valid_o, 0);
            end else begin
                assert (valid_o === 1'b1) else report_mismatch("valid_o", valid_o, 1);
            end
        end
        wait_drain();
    endtask

    task automatic test_throughput();
        for (int i = 0; i < 40; i++) begin
            issue_op(mul_uop_t'($random(seed)), $random(seed), $random(seed),
                     mul_tag_t'($random(seed)), 1'b0);
        end
        wait_drain();
    endtask

    // Random stall cycles and gaps between operations
    task automatic test_stalls();
        for (int i = 0; i < 40; i++) begin
            if ($random(seed) % 3 == 0) begin
                drive_idle(logic'($random(seed)));
            end
            issue_op(mul_uop_t'($random(seed)), $random(seed), $random(seed),
                     mul_tag_t'($random(seed)), 1'b1);
        end
        wait_drain();
    endtask

    initial begin
        rst_n_i        = 1'b0;
        clk_en_i       = 1'b1;
        valid_i        = 1'b0;
        op_i           = MUL;
        multiplicand_i = '0;
        multiplier_i   = '0;
        rd_tag_i       = '0;
        stalled_q      = 1'b0;
        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;

        check_reset();
        test_corners();
        test_latency();
        test_throughput();
        test_stalls();

        if (exp_product_q.size() == 0) begin
            $display("** PASS **");
            $finish;
        end else begin
            $display("Error: results are still outstanding at the end of the run");
            $display("** FAIL **");
            $fatal(1, "outstanding results");
        end
    end

endmodule : mul_tb
